/* hdl/beat_framer.sv */
//////////////////////////////////////////////////////////////////////
// Stage 1: registers beats, tags them with packet and word index
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "pkt_check_settings.svh"

module beat_framer (
    input  logic                        axis_packet_in,
    input  logic                        reset,
    input  logic                        beat_valid,
    input  pkt_check_pkg::axis_beat_t   beat,
    output logic                        framed_valid,
    output pkt_check_pkg::framed_beat_t framed
);

    localparam int DESTS = `PKT_DESTS;

    // Position trackers, one pair per destination
    logic [`PKT_WORDS_LOG-1:0] word_cnt [DESTS];
    logic [`PKT_SLOTS_LOG-1:0] pkt_cnt  [DESTS];

    //////////////////////////////////////////////////////////////////////
    // Counters

    always_ff @(posedge axis_packet_in) begin
        if (reset) begin
            for (int i = 0; i < DESTS; i++) begin
                word_cnt[i] <= '0;
                pkt_cnt[i]  <= '0;
            end
        end else if (beat_valid) begin
            if (beat.last) begin
                word_cnt[beat.dest] <= '0;
                pkt_cnt[beat.dest]  <= pkt_cnt[beat.dest] + 1'b1;
            end else begin
                word_cnt[beat.dest] <= word_cnt[beat.dest] + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output register

    always_ff @(posedge axis_packet_in) begin
        if (reset) begin
            framed_valid <= 1'b0;
        end else begin
            framed_valid <= beat_valid;
        end
    end

    // Tag with the values before this beat's update
    always_ff @(posedge axis_packet_in) begin
        if (beat_valid) begin
            framed.beat     <= beat;
            framed.pkt_idx  <= pkt_cnt[beat.dest];
            framed.word_idx <= word_cnt[beat.dest];
        end
    end

    // Packet longer than the word index can hold
    assert property (@(posedge axis_packet_in) disable iff (reset)
        beat_valid && !beat.last |-> word_cnt[beat.dest] != '1);

    // Partial keep only on the closing beat
    assert property (@(posedge axis_packet_in) disable iff (reset)
        beat_valid && !beat.last |-> &beat.keep);

endmodule

`default_nettype wire

/* hdl/expect_lookup.sv */
//////////////////////////////////////////////////////////////////////
// Stage 2: expected store, per-beat lookup of word and descriptor
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "pkt_check_settings.svh"

module expect_lookup (
    input  logic                          axis_packet_in,
    input  logic                          reset,
    input  logic                          load_valid,
    input  logic [`PKT_DEST_WIDTH-1:0]    load_dest,
    input  logic [`PKT_SLOTS_LOG-1:0]     load_pkt,
    input  logic [`PKT_WORDS_LOG-1:0]     load_word,
    input  pkt_check_pkg::data_word_t     load_data,
    input  logic                          desc_valid,
    input  logic [`PKT_DEST_WIDTH-1:0]    desc_dest,
    input  logic [`PKT_SLOTS_LOG-1:0]     desc_pkt,
    input  pkt_check_pkg::expect_desc_t   desc,
    input  logic                          framed_valid,
    input  pkt_check_pkg::framed_beat_t   framed,
    output logic                          lookup_valid,
    output pkt_check_pkg::lookup_beat_t   lookup,
    output logic [`PKT_TOTAL_WIDTH-1:0]   expected_total
);

    localparam int DESC_ADDR_BITS = `PKT_DEST_WIDTH + `PKT_SLOTS_LOG;
    localparam int DATA_ADDR_BITS = DESC_ADDR_BITS + `PKT_WORDS_LOG;

    logic [2**DESC_ADDR_BITS-1:0]   present_bits;
    logic                           present_q;
    pkt_check_pkg::framed_beat_t    framed_q;
    pkt_check_pkg::data_word_t      rd_word;
    pkt_check_pkg::expect_desc_t    rd_desc;
    logic [DESC_ADDR_BITS-1:0]      desc_slot;
    logic [DESC_ADDR_BITS-1:0]      beat_slot;

    assign desc_slot = {desc_dest, desc_pkt};
    assign beat_slot = {framed.beat.dest, framed.pkt_idx};

    //////////////////////////////////////////////////////////////////////
    // Store

    expect_ram #(
        .entry_t   (pkt_check_pkg::data_word_t),
        .ADDR_BITS (DATA_ADDR_BITS)
    ) u_data_ram (
        .axis_packet_in (axis_packet_in),
        .wr_en          (load_valid),
        .wr_addr        ({load_dest, load_pkt, load_word}),
        .wr_data        (load_data),
        .rd_addr        ({beat_slot, framed.word_idx}),
        .rd_data        (rd_word)
    );

    expect_ram #(
        .entry_t   (pkt_check_pkg::expect_desc_t),
        .ADDR_BITS (DESC_ADDR_BITS)
    ) u_desc_ram (
        .axis_packet_in (axis_packet_in),
        .wr_en          (desc_valid),
        .wr_addr        (desc_slot),
        .wr_data        (desc),
        .rd_addr        (beat_slot),
        .rd_data        (rd_desc)
    );

    // Slot bookkeeping, a rewritten descriptor is counted once
    always_ff @(posedge axis_packet_in) begin
        if (reset) begin
            present_bits   <= '0;
            expected_total <= '0;
        end else if (desc_valid) begin
            present_bits[desc_slot] <= 1'b1;
            if (!present_bits[desc_slot]) begin
                expected_total <= expected_total + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Beat delay to meet the RAM read

    always_ff @(posedge axis_packet_in) begin
        if (reset) begin
            lookup_valid <= 1'b0;
        end else begin
            lookup_valid <= framed_valid;
        end
    end

    always_ff @(posedge axis_packet_in) begin
        framed_q  <= framed;
        present_q <= present_bits[beat_slot];
    end

    assign lookup.framed   = framed_q;
    assign lookup.exp_data = rd_word;
    assign lookup.desc     = rd_desc;
    assign lookup.present  = present_q;

    // Store is frozen once traffic runs
    assert property (@(posedge axis_packet_in) disable iff (reset)
        framed_valid |-> !(load_valid || desc_valid));

endmodule

`default_nettype wire

/* hdl/expect_ram.sv */
//////////////////////////////////////////////////////////////////////
// Simple dual-port RAM, registered read, generic entry type
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module expect_ram #(
    parameter type entry_t   = logic [7:0],
    parameter int  ADDR_BITS = 4
) (
    input  logic                 axis_packet_in,
    input  logic                 wr_en,
    input  logic [ADDR_BITS-1:0] wr_addr,
    input  entry_t               wr_data,
    input  logic [ADDR_BITS-1:0] rd_addr,
    output entry_t               rd_data
);

    entry_t mem [2**ADDR_BITS];

    always_ff @(posedge axis_packet_in) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read every cycle, result one cycle later
    always_ff @(posedge axis_packet_in) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* hdl/packet_checker_top.sv */
//////////////////////////////////////////////////////////////////////
// Receive-side packet checker, four stage pipeline
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "pkt_check_settings.svh"

module packet_checker_top (
    input  logic                          axis_packet_in,
    input  logic                          reset,
    input  logic                          beat_valid,
    input  pkt_check_pkg::axis_beat_t     beat,
    input  logic                          load_valid,
    input  logic [`PKT_DEST_WIDTH-1:0]    load_dest,
    input  logic [`PKT_SLOTS_LOG-1:0]     load_pkt,
    input  logic [`PKT_WORDS_LOG-1:0]     load_word,
    input  pkt_check_pkg::data_word_t     load_data,
    input  logic                          desc_valid,
    input  logic [`PKT_DEST_WIDTH-1:0]    desc_dest,
    input  logic [`PKT_SLOTS_LOG-1:0]     desc_pkt,
    input  pkt_check_pkg::expect_desc_t   desc,
    output logic                          verdict_valid,
    output pkt_check_pkg::verdict_t       verdict,
    output logic [`PKT_COUNT_WIDTH-1:0]   pass_count,
    output logic [`PKT_COUNT_WIDTH-1:0]   fail_count,
    output logic                          error,
    output logic                          all_received
);

    logic                           framed_valid;
    pkt_check_pkg::framed_beat_t    framed;
    logic                           lookup_valid;
    pkt_check_pkg::lookup_beat_t    lookup;
    logic [`PKT_TOTAL_WIDTH-1:0]    expected_total;

    beat_framer u_framer (
        .axis_packet_in (axis_packet_in),
        .reset          (reset),
        .beat_valid     (beat_valid),
        .beat           (beat),
        .framed_valid   (framed_valid),
        .framed         (framed)
    );

    expect_lookup u_lookup (
        .axis_packet_in (axis_packet_in),
        .reset          (reset),
        .load_valid     (load_valid),
        .load_dest      (load_dest),
        .load_pkt       (load_pkt),
        .load_word      (load_word),
        .load_data      (load_data),
        .desc_valid     (desc_valid),
        .desc_dest      (desc_dest),
        .desc_pkt       (desc_pkt),
        .desc           (desc),
        .framed_valid   (framed_valid),
        .framed         (framed),
        .lookup_valid   (lookup_valid),
        .lookup         (lookup),
        .expected_total (expected_total)
    );

    packet_compare u_compare (
        .axis_packet_in (axis_packet_in),
        .reset          (reset),
        .lookup_valid   (lookup_valid),
        .lookup         (lookup),
        .verdict_valid  (verdict_valid),
        .verdict        (verdict)
    );

    pass_scoreboard u_scoreboard (
        .axis_packet_in (axis_packet_in),
        .reset          (reset),
        .verdict_valid  (verdict_valid),
        .verdict        (verdict),
        .expected_total (expected_total),
        .pass_count     (pass_count),
        .fail_count     (fail_count),
        .error          (error),
        .all_received   (all_received)
    );

endmodule

`default_nettype wire

/* hdl/packet_compare.sv */
//////////////////////////////////////////////////////////////////////
// Stage 3: byte compare and length count, verdict on last beat
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "pkt_check_settings.svh"

module packet_compare (
    input  logic                        axis_packet_in,
    input  logic                        reset,
    input  logic                        lookup_valid,
    input  pkt_check_pkg::lookup_beat_t lookup,
    output logic                        verdict_valid,
    output pkt_check_pkg::verdict_t     verdict
);

    localparam int DESTS = `PKT_DESTS;
    localparam int BYTES = `PKT_DATA_BYTES;
    localparam int LEN_W = `PKT_LEN_WIDTH;

    pkt_check_pkg::axis_beat_t  beat;
    logic [LEN_W-1:0]           len_acc [DESTS];
    logic                       bad_acc [DESTS];
    logic [LEN_W-1:0]           kept_bytes;
    logic                       byte_diff;
    logic [LEN_W-1:0]           len_next;
    logic                       bad_next;

    assign beat = lookup.framed.beat;

    //////////////////////////////////////////////////////////////////////
    // Per-beat compare

    always_comb begin
        kept_bytes = '0;
        byte_diff  = 1'b0;
        for (int i = 0; i < BYTES; i++) begin
            kept_bytes = kept_bytes + LEN_W'(beat.keep[i]);
            // Empty slot has no data worth comparing
            if (beat.keep[i] && lookup.present &&
                beat.data[i*8 +: 8] != lookup.exp_data[i*8 +: 8]) begin
                byte_diff = 1'b1;
            end
        end
        len_next = len_acc[beat.dest] + kept_bytes;
        bad_next = bad_acc[beat.dest] | byte_diff;
    end

    //////////////////////////////////////////////////////////////////////
    // Per-destination accumulators

    always_ff @(posedge axis_packet_in) begin
        if (reset) begin
            for (int i = 0; i < DESTS; i++) begin
                len_acc[i] <= '0;
                bad_acc[i] <= 1'b0;
            end
            verdict_valid <= 1'b0;
        end else begin
            verdict_valid <= lookup_valid && beat.last;
            if (lookup_valid) begin
                len_acc[beat.dest] <= beat.last ? '0 : len_next;
                bad_acc[beat.dest] <= beat.last ? 1'b0 : bad_next;
            end
        end
    end

    always_ff @(posedge axis_packet_in) begin
        if (lookup_valid && beat.last) begin
            verdict.dest     <= beat.dest;
            verdict.pkt_idx  <= lookup.framed.pkt_idx;
            verdict.byte_len <= len_next;
            verdict.present  <= lookup.present;
            verdict.len_ok   <= len_next == lookup.desc.byte_len;
            verdict.data_ok  <= !bad_next;
            verdict.match    <= lookup.present && !bad_next &&
                                len_next == lookup.desc.byte_len;
        end
    end

    // Running length agrees with the framer's word position
    assert property (@(posedge axis_packet_in) disable iff (reset)
        lookup_valid |->
            len_acc[beat.dest] == LEN_W'(lookup.framed.word_idx) * LEN_W'(BYTES));

endmodule

`default_nettype wire

/* hdl/pass_scoreboard.sv */
//////////////////////////////////////////////////////////////////////
// Stage 4: pass and fail counts, sticky error, completion level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "pkt_check_settings.svh"

module pass_scoreboard (
    input  logic                          axis_packet_in,
    input  logic                          reset,
    input  logic                          verdict_valid,
    input  pkt_check_pkg::verdict_t       verdict,
    input  logic [`PKT_TOTAL_WIDTH-1:0]   expected_total,
    output logic [`PKT_COUNT_WIDTH-1:0]   pass_count,
    output logic [`PKT_COUNT_WIDTH-1:0]   fail_count,
    output logic                          error,
    output logic                          all_received
);

    localparam int COUNT_W = `PKT_COUNT_WIDTH;

    //////////////////////////////////////////////////////////////////////
    // Counters

    always_ff @(posedge axis_packet_in) begin
        if (reset) begin
            pass_count <= '0;
            fail_count <= '0;
            error      <= 1'b0;
        end else if (verdict_valid) begin
            if (verdict.match) begin
                pass_count <= pass_count + 1'b1;
            end else begin
                fail_count <= fail_count + 1'b1;
                // Held until the next reset
                error      <= 1'b1;
            end
        end
    end

    // Done once every loaded slot has a passing verdict
    assign all_received = (expected_total != '0) &&
                          (pass_count == COUNT_W'(expected_total));

    //////////////////////////////////////////////////////////////////////
    // Checks

    assert property (@(posedge axis_packet_in) disable iff (reset)
        verdict_valid && verdict.match |-> pass_count != '1);

    assert property (@(posedge axis_packet_in) disable iff (reset)
        verdict_valid && !verdict.match |-> fail_count != '1);

endmodule

`default_nettype wire

/* hdl/pkt_check_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Packet checker types shared by all pipeline stages
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pkt_check_settings.svh"

package pkt_check_pkg;

    // One data word of a beat, also the entry of the data store
    typedef logic [`PKT_DATA_BYTES*8-1:0] data_word_t;

    // Input beat as seen on the stream
    typedef struct packed {
        data_word_t                  data;
        logic [`PKT_DATA_BYTES-1:0]  keep;
        logic                        last;
        logic [`PKT_DEST_WIDTH-1:0]  dest;
    } axis_beat_t;

    // Beat tagged with its slot and word position
    typedef struct packed {
        axis_beat_t                  beat;
        logic [`PKT_SLOTS_LOG-1:0]   pkt_idx;
        logic [`PKT_WORDS_LOG-1:0]   word_idx;
    } framed_beat_t;

    typedef struct packed {
        logic [`PKT_LEN_WIDTH-1:0]   byte_len;
    } expect_desc_t;

    // Beat joined with what the store holds for it
    typedef struct packed {
        framed_beat_t                framed;
        data_word_t                  exp_data;
        expect_desc_t                desc;
        logic                        present;
    } lookup_beat_t;

    typedef struct packed {
        logic [`PKT_DEST_WIDTH-1:0]  dest;
        logic [`PKT_SLOTS_LOG-1:0]   pkt_idx;
        logic [`PKT_LEN_WIDTH-1:0]   byte_len;
        logic                        present;
        logic                        len_ok;
        logic                        data_ok;
        logic                        match;
    } verdict_t;

endpackage

`default_nettype wire

/* hdl/pkt_check_settings.svh */
//////////////////////////////////////////////////////////////////////
// Packet checker sizes: beat width, destinations, expected slots
//////////////////////////////////////////////////////////////////////

`ifndef PKT_CHECK_SETTINGS_SVH
`define PKT_CHECK_SETTINGS_SVH

// Bytes per beat
`define PKT_DATA_BYTES 4

// Destination field width, four destinations
`define PKT_DEST_WIDTH 2
`define PKT_DESTS (1 << `PKT_DEST_WIDTH)

// Expected packets per destination and words per packet, as log2
`define PKT_SLOTS_LOG 2
`define PKT_WORDS_LOG 4

// Derived widths for lengths and counters
`define PKT_LEN_WIDTH (`PKT_WORDS_LOG + $clog2(`PKT_DATA_BYTES) + 1)
`define PKT_TOTAL_WIDTH (`PKT_DEST_WIDTH + `PKT_SLOTS_LOG + 1)
`define PKT_COUNT_WIDTH 8

`endif

/* sources.f */
+incdir+hdl
hdl/pkt_check_pkg.sv
hdl/expect_ram.sv
hdl/beat_framer.sv
hdl/expect_lookup.sv
hdl/packet_compare.sv
hdl/pass_scoreboard.sv
hdl/packet_checker_top.sv
verif/tb_packet_checker.sv

/* verif/tb_packet_checker.sv */
//////////////////////////////////////////////////////////////////////
// Directed testbench for the receive-side packet checker
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "pkt_check_settings.svh"

module tb_packet_checker;

    localparam int BYTES        = `PKT_DATA_BYTES;
    localparam int DESTS        = `PKT_DESTS;
    localparam int SLOTS        = 1 << `PKT_SLOTS_LOG;
    localparam int MAX_BYTES    = BYTES << `PKT_WORDS_LOG;
    localparam int COUNT_W      = `PKT_COUNT_WIDTH;
    localparam int RESET_CYCLES = 10;
    localparam int DRIVE_DELAY  = 2;
    // Whole sequence needs under 200 cycles
    localparam int CYCLE_LIMIT  = 2000;

    logic                                axis_packet_in;
    logic                                reset;
    logic                                beat_valid;
    pkt_check_pkg::axis_beat_t           beat;
    logic                                load_valid;
    logic [`PKT_DEST_WIDTH-1:0]          load_dest;
    logic [`PKT_SLOTS_LOG-1:0]           load_pkt;
    logic [`PKT_WORDS_LOG-1:0]           load_word;
    pkt_check_pkg::data_word_t           load_data;
    logic                                desc_valid;
    logic [`PKT_DEST_WIDTH-1:0]          desc_dest;
    logic [`PKT_SLOTS_LOG-1:0]           desc_pkt;
    pkt_check_pkg::expect_desc_t         desc;
    logic                                verdict_valid;
    pkt_check_pkg::verdict_t             verdict;
    logic [COUNT_W-1:0]                  pass_count;
    logic [COUNT_W-1:0]                  fail_count;
    logic                                error;
    logic                                all_received;

    // Stimulus packets and the reference copy of the expected store
    logic [7:0]  pkt_bytes [4][MAX_BYTES];
    int          pkt_len [4];
    logic [7:0]  store_bytes [DESTS][SLOTS][MAX_BYTES];
    int          store_len [DESTS][SLOTS];
    bit          store_present [DESTS][SLOTS];
    int          slot_next [DESTS];

    pkt_check_pkg::verdict_t  exp_want [$];
    pkt_check_pkg::verdict_t  exp_care [$];
    int                       exp_cycles [$];
    pkt_check_pkg::verdict_t  got_verdicts [$];
    int                       got_cycles [$];

    logic [31:0] lfsr_state;
    int          cycle;
    int          last_verdict_cycle;

    packet_checker_top DUT (
        .axis_packet_in (axis_packet_in),
        .reset          (reset),
        .beat_valid     (beat_valid),
        .beat           (beat),
        .load_valid     (load_valid),
        .load_dest      (load_dest),
        .load_pkt       (load_pkt),
        .load_word      (load_word),
        .load_data      (load_data),
        .desc_valid     (desc_valid),
        .desc_dest      (desc_dest),
        .desc_pkt       (desc_pkt),
        .desc           (desc),
        .verdict_valid  (verdict_valid),
        .verdict        (verdict),
        .pass_count     (pass_count),
        .fail_count     (fail_count),
        .error          (error),
        .all_received   (all_received)
    );

    //////////////////////////////////////////////////////////////////////
    // Clock, cycle count, verdict monitor

    initial axis_packet_in = 1'b0;
    always #20 axis_packet_in = ~axis_packet_in;

    always @(posedge axis_packet_in) begin
        cycle = cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
            stop_run();
        end
    end

    // Sampled mid-cycle, away from the clock edge
    always @(negedge axis_packet_in) begin
        if (verdict_valid === 1'b1) begin
            got_verdicts.push_back(verdict);
            got_cycles.push_back(cycle);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reporting and compare tasks

    task automatic stop_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_verdict(input string name, input pkt_check_pkg::verdict_t got,
                                 input pkt_check_pkg::verdict_t want,
                                 input pkt_check_pkg::verdict_t care);
        if (((got ^ want) & care) !== '0) begin
            $display("CHECK FAILED at time %0t: %s got %h expected %h", $time, name, got, want);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input logic [COUNT_W-1:0] got,
                               input logic [COUNT_W-1:0] want);
        if (got !== want) begin
            $display("CHECK FAILED at time %0t: %s got %0d expected %0d", $time, name, got, want);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("CHECK FAILED at time %0t: %s got %b expected %b", $time, name, got, want);
            stop_run();
        end
    endtask

    task automatic check_cycle(input string name, input int got, input int want);
        if (got != want) begin
            $display("CHECK FAILED at time %0t: %s got %0d expected %0d", $time, name, got, want);
            stop_run();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus and reference model

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic make_packet(input int id, input int len);
        logic [7:0] b;
        pkt_len[id] = len;
        for (int i = 0; i < len; i++) begin
            b = '0;
            for (int k = 0; k < 8; k++) begin
                lfsr_state = lfsr_step(lfsr_state);
                b = {b[6:0], lfsr_state[0]};
            end
            pkt_bytes[id][i] = b;
        end
    endtask

    function automatic logic [7:0] sent_byte(input int id, input int idx, input int flip);
        return (idx == flip) ? ~pkt_bytes[id][idx] : pkt_bytes[id][idx];
    endfunction

    task automatic clear_model();
        for (int d = 0; d < DESTS; d++) begin
            slot_next[d] = 0;
            for (int s = 0; s < SLOTS; s++) begin
                store_present[d][s] = 1'b0;
                store_len[d][s]     = 0;
            end
        end
    endtask

    task automatic expect_verdict(input int dest, input int slot, input int id, input int len,
                                  input int flip, output pkt_check_pkg::verdict_t want,
                                  output pkt_check_pkg::verdict_t care);
        logic same;
        same     = 1'b1;
        care     = '1;
        want     = '0;
        want.dest     = dest[`PKT_DEST_WIDTH-1:0];
        want.pkt_idx  = slot[`PKT_SLOTS_LOG-1:0];
        want.byte_len = len[`PKT_LEN_WIDTH-1:0];
        want.present  = store_present[dest][slot];
        if (want.present) begin
            for (int i = 0; i < len; i++) begin
                if (sent_byte(id, i, flip) != store_bytes[dest][slot][i]) begin
                    same = 1'b0;
                end
            end
            want.len_ok  = (len == store_len[dest][slot]);
            want.data_ok = same;
        end else begin
            // Descriptor never written, so its length is unknown
            want.len_ok  = 1'b0;
            care.len_ok  = 1'b0;
            want.data_ok = 1'b1;
        end
        want.match = want.present && want.len_ok && want.data_ok;
    endtask

    task automatic load_packet(input int id, input int dest, input int slot);
        for (int w = 0; w * BYTES < pkt_len[id]; w++) begin
            @(posedge axis_packet_in);
            #DRIVE_DELAY;
            load_valid = 1'b1;
            load_dest  = dest[`PKT_DEST_WIDTH-1:0];
            load_pkt   = slot[`PKT_SLOTS_LOG-1:0];
            load_word  = w[`PKT_WORDS_LOG-1:0];
            for (int i = 0; i < BYTES; i++) begin
                load_data[i*8 +: 8] = (w * BYTES + i < pkt_len[id]) ?
                                      pkt_bytes[id][w * BYTES + i] : 8'h00;
            end
        end
        @(posedge axis_packet_in);
        #DRIVE_DELAY;
        load_valid    = 1'b0;
        desc_valid    = 1'b1;
        desc_dest     = dest[`PKT_DEST_WIDTH-1:0];
        desc_pkt      = slot[`PKT_SLOTS_LOG-1:0];
        desc.byte_len = pkt_len[id][`PKT_LEN_WIDTH-1:0];
        @(posedge axis_packet_in);
        #DRIVE_DELAY;
        desc_valid = 1'b0;
        for (int i = 0; i < pkt_len[id]; i++) begin
            store_bytes[dest][slot][i] = pkt_bytes[id][i];
        end
        store_len[dest][slot]     = pkt_len[id];
        store_present[dest][slot] = 1'b1;
    endtask

    // One beat, the verdict is due three cycles after a last beat
    task automatic drive_beat(input int id, input int dest, input int word, input int len,
                              input int flip);
        pkt_check_pkg::axis_beat_t b;
        pkt_check_pkg::verdict_t   want;
        pkt_check_pkg::verdict_t   care;
        int                        first;
        first  = word * BYTES;
        b.data = '0;
        b.keep = '0;
        for (int i = 0; i < BYTES; i++) begin
            if (first + i < len) begin
                b.data[i*8 +: 8] = sent_byte(id, first + i, flip);
                b.keep[i]        = 1'b1;
            end
        end
        b.last = (first + BYTES >= len);
        b.dest = dest[`PKT_DEST_WIDTH-1:0];
        @(posedge axis_packet_in);
        #DRIVE_DELAY;
        beat       = b;
        beat_valid = 1'b1;
        if (b.last) begin
            expect_verdict(dest, slot_next[dest], id, len, flip, want, care);
            exp_want.push_back(want);
            exp_care.push_back(care);
            exp_cycles.push_back(cycle + 3);
            slot_next[dest] = (slot_next[dest] + 1) % SLOTS;
        end
    endtask

    task automatic end_traffic();
        @(posedge axis_packet_in);
        #DRIVE_DELAY;
        beat_valid = 1'b0;
    endtask

    task automatic send_packet(input int id, input int dest, input int len, input int flip);
        for (int w = 0; w * BYTES < len; w++) begin
            drive_beat(id, dest, w, len, flip);
        end
        end_traffic();
    endtask

    task automatic take_verdict();
        pkt_check_pkg::verdict_t got;
        int                      got_cycle;
        while (got_verdicts.size() == 0) begin
            @(negedge axis_packet_in);
        end
        got       = got_verdicts.pop_front();
        got_cycle = got_cycles.pop_front();
        if (exp_want.size() == 0) begin
            $display("A verdict arrived with no packet sent for it");
            stop_run();
        end
        check_verdict("verdict", got, exp_want.pop_front(), exp_care.pop_front());
        check_cycle("verdict_valid cycle", got_cycle, exp_cycles.pop_front());
        last_verdict_cycle = got_cycle;
    endtask

    // Counters move one cycle after the verdict
    task automatic check_scoreboard(input int pass_want, input int fail_want,
                                    input logic err_want, input logic all_want);
        while (cycle < last_verdict_cycle + 1) begin
            @(negedge axis_packet_in);
        end
        check_count("pass_count", pass_count, COUNT_W'(pass_want));
        check_count("fail_count", fail_count, COUNT_W'(fail_want));
        check_flag("error", error, err_want);
        check_flag("all_received", all_received, all_want);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic test_clean_packet();
        load_packet(0, 0, 0);
        load_packet(1, 1, 0);
        load_packet(2, 2, 0);
        send_packet(0, 0, pkt_len[0], -1);
        take_verdict();
        check_scoreboard(1, 0, 1'b0, 1'b0);
    endtask

    task automatic test_interleaved();
        int beats_b;
        int beats_c;
        beats_b = (pkt_len[1] + BYTES - 1) / BYTES;
        beats_c = (pkt_len[2] + BYTES - 1) / BYTES;
        for (int w = 0; w < beats_b || w < beats_c; w++) begin
            if (w < beats_b) begin
                drive_beat(1, 1, w, pkt_len[1], -1);
            end
            if (w < beats_c) begin
                drive_beat(2, 2, w, pkt_len[2], -1);
            end
        end
        end_traffic();
        take_verdict();
        take_verdict();
        check_scoreboard(3, 0, 1'b0, 1'b1);
    endtask

    task automatic test_flipped_byte();
        load_packet(0, 0, 1);
        load_packet(0, 0, 2);
        @(negedge axis_packet_in);
        check_flag("all_received", all_received, 1'b0);
        send_packet(0, 0, pkt_len[0], 5);
        take_verdict();
        check_scoreboard(1, 1, 1'b1, 1'b0);
    endtask

    task automatic test_short_packet();
        send_packet(0, 0, pkt_len[0] - 1, -1);
        take_verdict();
        check_scoreboard(1, 2, 1'b1, 1'b0);
    endtask

    // A failed slot leaves the completion level high
    task automatic test_missing_descriptor();
        send_packet(3, 3, pkt_len[3], -1);
        take_verdict();
        check_scoreboard(3, 1, 1'b1, 1'b1);
    endtask

    task automatic test_reset_rerun();
        @(posedge axis_packet_in);
        #DRIVE_DELAY;
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge axis_packet_in);
        #DRIVE_DELAY;
        reset = 1'b0;
        clear_model();
        last_verdict_cycle = cycle;
        @(negedge axis_packet_in);
        check_scoreboard(0, 0, 1'b0, 1'b0);
        load_packet(0, 0, 0);
        send_packet(0, 0, pkt_len[0], -1);
        take_verdict();
        check_scoreboard(1, 0, 1'b0, 1'b1);
    endtask

    initial begin
        lfsr_state         = 32'h6f57;
        cycle              = 0;
        last_verdict_cycle = 0;
        reset              = 1'b1;
        beat_valid         = 1'b0;
        beat               = '0;
        load_valid         = 1'b0;
        load_dest          = '0;
        load_pkt           = '0;
        load_word          = '0;
        load_data          = '0;
        desc_valid         = 1'b0;
        desc_dest          = '0;
        desc_pkt           = '0;
        desc               = '0;
        clear_model();
        make_packet(0, 16);
        make_packet(1, 22);
        make_packet(2, 9);
        make_packet(3, 8);
        repeat (RESET_CYCLES) @(posedge axis_packet_in);
        #DRIVE_DELAY;
        reset = 1'b0;

        test_clean_packet();
        test_interleaved();
        test_missing_descriptor();
        test_reset_rerun();
        test_flipped_byte();
        test_short_packet();

        // Let a late or repeated verdict reach the monitor
        repeat (2) @(posedge axis_packet_in);
        if (got_verdicts.size() == 0 && exp_want.size() == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("Verdicts left over at the end of the run");
            stop_run();
        end
    end

endmodule

`default_nettype wire
